/* hdl/conv_cfg.svh */
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Activation width, also the number of bit planes
`define CONV_DATA_SIZE 4
`define CONV_BUS_WIDTH 8        // Activations per crossbar write
`define CONV_NUM_ADDR  4        // Bus words per plane
`define CONV_NUM_IN    32       // Crossbar rows
`define CONV_NUM_COLS  4        // Crossbar output columns

// Index widths
`define CONV_ADDR_W    2        // Word address
`define CONV_COUNT_W   2        // Plane count
`define CONV_IDX_W     5        // Activation index

// Busy cycles of the crossbar and the function unit
`define CONV_CIM_LAT   3
`define CONV_FUNC_LAT  2

`define CONV_OUT_SHIFT 0        // Right shift before saturation
`define CONV_OUT_W     8        // Result width per column

`endif

/* hdl/conv_pkg.sv */
package conv_pkg;

    typedef enum logic [1:0] {
        s_conv_ctrl_idle,       // Waiting for a run request
        s_conv_ctrl_consume,    // Bus words into crossbar
        s_conv_ctrl_start,      // Crossbar start held
        s_conv_ctrl_wait        // Crossbar busy
    } conv_ctrl_state_t;

    // One column, one plane: range -32 to 32
    typedef logic signed [6:0] psum_t;

    // Full dot product over four planes, max magnitude 480
    typedef logic signed [11:0] acc_t;

endpackage

/* hdl/conv_ctrl.sv */
`include "conv_cfg.svh"

module conv_ctrl import conv_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_start,
    input  logic                     i_cim_ready,
    input  logic                     i_func_ready,
    output logic                     o_ready,
    output logic                     o_cim_we,
    output logic                     o_cim_start,
    output logic                     o_func_start,
    output logic [`CONV_ADDR_W-1:0]  o_addr,
    output logic [`CONV_COUNT_W-1:0] o_count
);

    localparam int ADDR_W  = `CONV_ADDR_W;
    localparam int COUNT_W = `CONV_COUNT_W;
    localparam logic [ADDR_W-1:0]  LAST_ADDR  = ADDR_W'(`CONV_NUM_ADDR - 1);
    localparam logic [COUNT_W-1:0] LAST_COUNT = COUNT_W'(`CONV_DATA_SIZE - 1);

    conv_ctrl_state_t state, next_state;
    logic [ADDR_W-1:0]  addr, next_addr;
    logic [COUNT_W-1:0] count, next_count;

    assign o_addr  = addr;
    assign o_count = count;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_conv_ctrl_idle;
            addr  <= '0;
            count <= '0;
        end else begin
            state <= next_state;
            addr  <= next_addr;
            count <= next_count;
        end
    end

    always_comb begin
        next_state   = state;
        next_addr    = addr;
        next_count   = count;
        o_ready      = 1'b0;
        o_cim_we     = 1'b0;
        o_cim_start  = 1'b0;
        o_func_start = 1'b0;
        case (state)
            s_conv_ctrl_idle: begin
                o_ready    = 1'b1;
                next_addr  = '0;
                next_count = '0;
                if (i_start && i_cim_ready) begin // Accept only with crossbar free
                    next_state = s_conv_ctrl_consume;
                end
            end
            s_conv_ctrl_consume: begin
                o_cim_we = 1'b1;
                if (addr == LAST_ADDR) begin // Whole plane written
                    next_state = s_conv_ctrl_start;
                end else begin
                    next_addr = addr + 1'b1;
                end
            end
            s_conv_ctrl_start: begin
                next_addr = '0;
                if (!i_cim_ready) begin // Crossbar has gone busy
                    next_state = s_conv_ctrl_wait;
                end else begin
                    o_cim_start = 1'b1;
                end
            end
            s_conv_ctrl_wait: begin
                next_addr = '0;
                if (i_cim_ready) begin
                    if (count == LAST_COUNT) begin
                        // Last plane done, hand over once the function unit is free
                        if (i_func_ready) begin
                            o_func_start = 1'b1;
                            next_state   = s_conv_ctrl_idle;
                        end
                    end else begin
                        next_count = count + 1'b1; // Next lower plane
                        next_state = s_conv_ctrl_consume;
                    end
                end
            end
            default: next_state = s_conv_ctrl_idle;
        endcase
    end

    a_we_start_excl: assert property (@(posedge clk) disable iff (rst)
        !(o_cim_we && o_cim_start));

    a_func_start_ready: assert property (@(posedge clk) disable iff (rst)
        o_func_start |-> i_func_ready);

endmodule

/* hdl/conv_ibuf.sv */
`include "conv_cfg.svh"

module conv_ibuf (
    input  logic                      clk,
    input  logic                      i_we,
    input  logic [`CONV_IDX_W-1:0]    i_waddr,
    input  logic [`CONV_DATA_SIZE-1:0] i_wdata,
    input  logic [`CONV_ADDR_W-1:0]   i_addr,
    input  logic [`CONV_COUNT_W-1:0]  i_count,
    output logic [`CONV_BUS_WIDTH-1:0] o_plane_bits
);

    localparam int BUS_W   = `CONV_BUS_WIDTH;
    localparam int IDX_W   = `CONV_IDX_W;
    localparam int COUNT_W = `CONV_COUNT_W;

    logic [`CONV_DATA_SIZE-1:0] act_mem [`CONV_NUM_IN];
    logic [COUNT_W-1:0]         bit_sel;

    always_ff @(posedge clk) begin
        if (i_we) begin
            act_mem[i_waddr] <= i_wdata;
        end
    end

    // Plane 0 is the MSB of each activation
    assign bit_sel = COUNT_W'(`CONV_DATA_SIZE - 1) - i_count;

    // One bit of eight neighbouring activations
    always_comb begin
        for (int j = 0; j < BUS_W; j++) begin
            o_plane_bits[j] = act_mem[IDX_W'(int'(i_addr) * BUS_W + j)][bit_sel];
        end
    end

endmodule

/* hdl/cim_xbar.sv */
`include "conv_cfg.svh"

module cim_xbar import conv_pkg::*; (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_w_we,
    input  logic [$clog2(`CONV_NUM_COLS)-1:0]  i_w_col,
    input  logic [`CONV_NUM_IN-1:0]            i_w_data,
    input  logic                               i_we,
    input  logic [`CONV_ADDR_W-1:0]            i_addr,
    input  logic [`CONV_BUS_WIDTH-1:0]         i_in_bits,
    input  logic                               i_start,
    output logic                               o_ready,
    output logic                               o_psum_valid,
    output psum_t [`CONV_NUM_COLS-1:0]         o_psum
);

    localparam int NUM_IN   = `CONV_NUM_IN;
    localparam int NUM_COLS = `CONV_NUM_COLS;
    localparam int BUS_W    = `CONV_BUS_WIDTH;
    localparam int LAT      = `CONV_CIM_LAT;
    localparam int CNT_W    = $clog2(LAT + 1);

    logic [NUM_IN-1:0]           weights [NUM_COLS]; // Bit 1 is +1, bit 0 is -1
    logic [NUM_IN-1:0]           in_reg;
    logic [CNT_W-1:0]            busy_cnt;
    psum_t [NUM_COLS-1:0]        col_sum;

    always_ff @(posedge clk) begin
        if (i_w_we) begin
            weights[i_w_col] <= i_w_data;
        end
        if (i_we) begin
            in_reg[int'(i_addr) * BUS_W +: BUS_W] <= i_in_bits;
        end
    end

    // Signed column sums over the active input rows
    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            col_sum[c] = '0;
            for (int i = 0; i < NUM_IN; i++) begin
                if (in_reg[i]) begin
                    col_sum[c] = weights[c][i] ? col_sum[c] + psum_t'(1)
                                               : col_sum[c] - psum_t'(1);
                end
            end
        end
    end

    assign o_ready = (busy_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_cnt     <= '0;
            o_psum_valid <= 1'b0;
        end else begin
            o_psum_valid <= (busy_cnt == CNT_W'(1)); // Last busy cycle
            if (i_start && o_ready) begin
                busy_cnt <= CNT_W'(LAT);
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start && o_ready) begin
            o_psum <= col_sum; // Held until next start
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(i_start) |-> o_ready);

endmodule

/* hdl/bitserial_acc.sv */
`include "conv_cfg.svh"

module bitserial_acc import conv_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_psum_valid,
    input  psum_t [`CONV_NUM_COLS-1:0]   i_psum,
    input  logic [`CONV_COUNT_W-1:0]     i_count,
    output acc_t [`CONV_NUM_COLS-1:0]    o_acc
);

    localparam int NUM_COLS = `CONV_NUM_COLS;

    // Planes arrive MSB first, so each new plane doubles the running sum
    always_ff @(posedge clk) begin
        if (rst) begin
            o_acc <= '0;
        end else if (i_psum_valid) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                if (i_count == '0) begin
                    o_acc[c] <= acc_t'(i_psum[c]); // First plane loads
                end else begin
                    o_acc[c] <= (o_acc[c] <<< 1) + acc_t'(i_psum[c]);
                end
            end
        end
    end

endmodule

/* hdl/conv_func.sv */
`include "conv_cfg.svh"

module conv_func import conv_pkg::*; (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_start,
    input  acc_t [`CONV_NUM_COLS-1:0]              i_acc,
    output logic                                   o_ready,
    output logic                                   o_valid,
    output logic [`CONV_NUM_COLS*`CONV_OUT_W-1:0]  o_data
);

    localparam int NUM_COLS = `CONV_NUM_COLS;
    localparam int OUT_W    = `CONV_OUT_W;
    localparam int LAT      = `CONV_FUNC_LAT;
    localparam int CNT_W    = $clog2(LAT + 1);

    logic [CNT_W-1:0]     busy_cnt;
    logic                 load_pend;
    acc_t [NUM_COLS-1:0]  acc_q;

    // ReLU, shift, clamp to the output range
    function automatic logic [OUT_W-1:0] relu_sat(input acc_t a);
        acc_t shifted;
        shifted = a >>> `CONV_OUT_SHIFT;
        if (a < 0) begin
            return '0;
        end else if (shifted > acc_t'((1 << OUT_W) - 1)) begin
            return '1;
        end
        return shifted[OUT_W-1:0];
    endfunction

    assign o_ready = (busy_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_cnt  <= '0;
            load_pend <= 1'b0;
            o_valid   <= 1'b0;
        end else begin
            load_pend <= i_start && o_ready;
            o_valid   <= (busy_cnt == CNT_W'(1));
            if (i_start && o_ready) begin
                busy_cnt <= CNT_W'(LAT);
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
        end
    end

    // The last plane lands in the accumulator on the start edge, so sample one cycle on
    always_ff @(posedge clk) begin
        if (load_pend) begin
            acc_q <= i_acc;
        end
        if (busy_cnt == CNT_W'(1)) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                o_data[c*OUT_W +: OUT_W] <= relu_sat(acc_q[c]); // Column 0 low byte
            end
        end
    end

    a_valid_when_idle: assert property (@(posedge clk) disable iff (rst)
        o_valid |-> o_ready);

endmodule

/* hdl/conv_layer_top.sv */
`include "conv_cfg.svh"

module conv_layer_top import conv_pkg::*; (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_act_we,
    input  logic [`CONV_IDX_W-1:0]                 i_act_waddr,
    input  logic [`CONV_DATA_SIZE-1:0]             i_act_wdata,
    input  logic                                   i_w_we,
    input  logic [$clog2(`CONV_NUM_COLS)-1:0]      i_w_col,
    input  logic [`CONV_NUM_IN-1:0]                i_w_data,
    input  logic                                   i_start,
    output logic                                   o_ready,
    output logic                                   o_out_valid,
    output logic [`CONV_NUM_COLS*`CONV_OUT_W-1:0]  o_out_data
);

    logic [`CONV_ADDR_W-1:0]       addr;
    logic [`CONV_COUNT_W-1:0]      count;
    logic                          cim_we;
    logic                          cim_start;
    logic                          cim_ready;
    logic                          func_start;
    logic                          func_ready;
    logic [`CONV_BUS_WIDTH-1:0]    plane_bits;
    logic                          psum_valid;
    psum_t [`CONV_NUM_COLS-1:0]    psum;
    acc_t [`CONV_NUM_COLS-1:0]     acc;

    conv_ctrl ctrl0 (
        .clk(clk), .rst(rst), .i_start(i_start), .i_cim_ready(cim_ready),
        .i_func_ready(func_ready), .o_ready(o_ready), .o_cim_we(cim_we),
        .o_cim_start(cim_start), .o_func_start(func_start), .o_addr(addr), .o_count(count)
    );

    conv_ibuf ibuf0 (
        .clk(clk), .i_we(i_act_we), .i_waddr(i_act_waddr), .i_wdata(i_act_wdata),
        .i_addr(addr), .i_count(count), .o_plane_bits(plane_bits)
    );

    cim_xbar xbar0 (
        .clk(clk), .rst(rst), .i_w_we(i_w_we), .i_w_col(i_w_col), .i_w_data(i_w_data),
        .i_we(cim_we), .i_addr(addr), .i_in_bits(plane_bits), .i_start(cim_start),
        .o_ready(cim_ready), .o_psum_valid(psum_valid), .o_psum(psum)
    );

    bitserial_acc acc0 (
        .clk(clk), .rst(rst), .i_psum_valid(psum_valid), .i_psum(psum),
        .i_count(count), .o_acc(acc)
    );

    conv_func func0 (
        .clk(clk), .rst(rst), .i_start(func_start), .i_acc(acc),
        .o_ready(func_ready), .o_valid(o_out_valid), .o_data(o_out_data)
    );

endmodule

/* tb/tb_conv_layer.sv */
`include "conv_cfg.svh"

module tb_conv_layer;

    localparam int NUM_RUNS        = 40;                // Completed plus aborted runs
    localparam int RUN_CYCLES      = 200;               // Upper bound for one run
    localparam int WATCHDOG_CYCLES = RUN_CYCLES * NUM_RUNS;
    localparam int NUM_IN          = `CONV_NUM_IN;
    localparam int NUM_COLS        = `CONV_NUM_COLS;

    localparam int A_RANDOM = 0;
    localparam int A_MAX    = 1;
    localparam int A_ZERO   = 2;
    localparam int W_RANDOM = 0;
    localparam int W_PLUS   = 1;
    localparam int W_MINUS  = 2;
    localparam int START_PULSE   = 0;                   // One-cycle request
    localparam int START_HOLD    = 1;                   // Held while busy
    localparam int START_REPULSE = 2;                   // Random toggling while busy

    logic        clk;
    logic        rst;
    logic        i_act_we;
    logic [4:0]  i_act_waddr;
    logic [3:0]  i_act_wdata;
    logic        i_w_we;
    logic [1:0]  i_w_col;
    logic [31:0] i_w_data;
    logic        i_start;
    logic        o_ready;
    logic        o_out_valid;
    logic [31:0] o_out_data;

    int          act_m [NUM_IN];                        // Activation mirror
    logic [31:0] w_m [NUM_COLS];                        // Weight mirror with 1 as +1
    int unsigned seed_val;

    conv_layer_top dut0 (
        .clk(clk), .rst(rst), .i_act_we(i_act_we), .i_act_waddr(i_act_waddr),
        .i_act_wdata(i_act_wdata), .i_w_we(i_w_we), .i_w_col(i_w_col), .i_w_data(i_w_data),
        .i_start(i_start), .o_ready(o_ready), .o_out_valid(o_out_valid),
        .o_out_data(o_out_data)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Signed dot product per column, then ReLU, shift and clamp to 255
    function automatic logic [31:0] model_out();
        logic [31:0] packed_out;
        int sum;
        int r;
        packed_out = '0;
        for (int c = 0; c < NUM_COLS; c++) begin
            sum = 0;
            for (int i = 0; i < NUM_IN; i++) begin
                sum += w_m[c][i] ? act_m[i] : -act_m[i];
            end
            r = (sum < 0) ? 0 : (sum >>> `CONV_OUT_SHIFT);
            if (r > 255) begin
                r = 255;
            end
            packed_out[c*8 +: 8] = 8'(r);               // Column 0 low byte
        end
        return packed_out;
    endfunction

    task automatic load_acts(input int mode);
        int val;
        check_value("o_ready", 32'(o_ready), 32'd1);
        for (int i = 0; i < NUM_IN; i++) begin
            val = (mode == A_RANDOM) ? int'($urandom_range(15, 0)) : (mode == A_MAX) ? 15 : 0;
            act_m[i] = val;
            @(negedge clk);
            i_act_we    = 1'b1;
            i_act_waddr = 5'(i);
            i_act_wdata = 4'(val);
        end
        @(negedge clk);
        i_act_we = 1'b0;
    endtask

    task automatic load_weights(input int mode);
        check_value("o_ready", 32'(o_ready), 32'd1);
        for (int c = 0; c < NUM_COLS; c++) begin
            w_m[c] = (mode == W_RANDOM) ? $urandom() : (mode == W_PLUS) ? '1 : '0;
            @(negedge clk);
            i_w_we   = 1'b1;
            i_w_col  = 2'(c);
            i_w_data = w_m[c];
        end
        @(negedge clk);
        i_w_we = 1'b0;
    endtask

    // One full run with extra start activity while the stage is busy
    task automatic do_run(input int mode, input logic [31:0] exp_data);
        int pulses;
        bit ready_rose;
        bit got_valid;
        pulses     = 0;
        ready_rose = 1'b0;
        got_valid  = 1'b0;
        @(negedge clk);
        check_value("o_ready", 32'(o_ready), 32'd1);
        i_start = 1'b1;
        @(negedge clk);
        check_value("o_ready_after_accept", 32'(o_ready), 32'd0);
        while (!got_valid) begin
            if (o_out_valid) begin
                got_valid = 1'b1;
                pulses++;
                check_value("o_ready_rose_before_valid", 32'(ready_rose), 32'd1);
                check_value("o_out_data", o_out_data, exp_data);
            end else begin
                if (o_ready) begin
                    ready_rose = 1'b1;
                    i_start    = 1'b0;                  // Never re-request once idle
                end else if (mode == START_PULSE) begin
                    i_start = 1'b0;
                end else if (mode == START_HOLD) begin
                    i_start = 1'b1;
                end else begin
                    i_start = 1'($urandom_range(1, 0));
                end
                @(negedge clk);
            end
        end
        i_start = 1'b0;
        repeat (8) begin
            @(negedge clk);
            if (o_out_valid) begin
                pulses++;
            end
            check_value("o_out_data_hold", o_out_data, exp_data);
        end
        check_value("o_out_valid_pulses", 32'(pulses), 32'd1);
    endtask

    // Reset lands after max_delay cycles or as soon as the function unit takes over
    task automatic abort_run(input int max_delay);
        int waited;
        waited = 0;
        @(negedge clk);
        check_value("o_ready", 32'(o_ready), 32'd1);
        i_start = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
        check_value("o_ready_after_accept", 32'(o_ready), 32'd0);
        while (!o_ready && waited < max_delay) begin
            @(negedge clk);
            waited++;
        end
        rst = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("o_out_valid_in_reset", 32'(o_out_valid), 32'd0);
        end
        rst = 1'b0;
        repeat (10) begin
            check_value("o_ready_after_reset", 32'(o_ready), 32'd1);
            check_value("o_out_valid_after_reset", 32'(o_out_valid), 32'd0);
            @(negedge clk);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: a run started but its result never arrived");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed_val    = $urandom(20);
        clk         = 1'b0;
        rst         = 1'b1;
        i_act_we    = 1'b0;
        i_act_waddr = '0;
        i_act_wdata = '0;
        i_w_we      = 1'b0;
        i_w_col     = '0;
        i_w_data    = '0;
        i_start     = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("o_ready_after_reset", 32'(o_ready), 32'd1);
        check_value("o_out_valid_after_reset", 32'(o_out_valid), 32'd0);

        for (int r = 0; r < 30; r++) begin
            load_weights(W_RANDOM);
            load_acts(A_RANDOM);
            do_run(r % 3, model_out());
        end

        // Weights stay from the last random run
        repeat (3) begin
            load_acts(A_RANDOM);
            do_run(START_PULSE, model_out());
        end

        load_acts(A_MAX);
        load_weights(W_PLUS);
        do_run(START_HOLD, 32'hffff_ffff);              // 480 clamps to 255
        load_weights(W_MINUS);
        do_run(START_REPULSE, 32'h0000_0000);
        load_acts(A_ZERO);
        load_weights(W_RANDOM);
        do_run(START_PULSE, 32'h0000_0000);

        // First abort hits the crossbar phase, the second one the function unit
        for (int r = 0; r < 2; r++) begin
            load_acts(A_RANDOM);
            load_weights(W_RANDOM);
            abort_run((r == 0) ? int'($urandom_range(30, 1)) : RUN_CYCLES);
            do_run(r + 1, model_out());
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/conv_pkg.sv
hdl/conv_ctrl.sv
hdl/conv_ibuf.sv
hdl/cim_xbar.sv
hdl/bitserial_acc.sv
hdl/conv_func.sv
hdl/conv_layer_top.sv
tb/tb_conv_layer.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CIM convolution stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_conv_layer -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_conv_layer 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
